// File: verif/shooter_golden.txt
// columns: ship_x frames alive_mask kills level, all hex
// one shot per line, fired a few cycles after a frame tick
// level 0, aimed at enemy 1, 3, then through dead 1, a gap, then 0 and 2
177 3c d 1 0
2ca 3c 5 2 0
15b 48 5 2 0
1c2 48 5 2 0
06b 3c 4 3 0
22a 3c f 0 1
// level 1, a gap shot, then a shot that only hits with the offset restarted
0fa 48 f 0 1
16e 3c d 1 1
1f9 3c 9 2 1
09c 3c 8 3 1
30f 3c f 0 2
// level 2, a miss at the far left
014 48 f 0 2

// File: compile.f
src/game_geom_pkg.sv
src/game_ctrl_pkg.sv
src/missile_launcher.sv
src/enemy_formation.sv
src/enemy_hit_detect.sv
src/level_control.sv
src/shooter_core.sv
verif/shooter_core_tb.sv

// File: Makefile
TOP = shooter_core_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall -Wno-fatal --timing --top-module shooter_core -f compile.f

sim:
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

// File: verif/shooter_core_tb.sv
// ----------------------------------------
// shooter core testbench
// directed and golden-file shots against
// the playfield, with credit tracking
// ----------------------------------------

`timescale 1ns/1ps

module shooter_core_tb;

  import game_geom_pkg::*;
  import game_ctrl_pkg::*;

  localparam int NUM_SHOTS    = 12;
  localparam int SHOT_FIELDS  = 5;
  localparam int FRAME_CYCLES = 16;
  localparam int TICK_LIMIT   = 3 * FRAME_CYCLES;
  localparam int CREDIT_LIMIT = 80 * FRAME_CYCLES;

  logic                      pclk;
  logic                      rst;
  logic                      frame_tick;
  coord_t                    ship_x;
  logic                      fire;
  logic                      fire_credit;
  enemy_mask_t               alive_mask;
  kill_cnt_t                 kills;
  level_t                    level;
  logic                      level_change;
  coord_t [NUM_MISSILES-1:0] missile_x;
  coord_t [NUM_MISSILES-1:0] missile_y;
  logic [NUM_MISSILES-1:0]   missile_active;

  // five words per shot as laid out in the data file
  logic [15:0] golden [SHOT_FIELDS*NUM_SHOTS];
  logic [31:0] rng_state = 32'hb02a_2ab2;
  int          errors = 0;
  int          checks = 0;
  int          fires_sent = 0;
  int          credits_back = 0;
  int          lc_pulses = 0;
  logic        timed_out = 1'b0;

  shooter_core dut (
    .pclk          (pclk),
    .rst           (rst),
    .frame_tick    (frame_tick),
    .ship_x        (ship_x),
    .fire          (fire),
    .fire_credit   (fire_credit),
    .alive_mask    (alive_mask),
    .kills         (kills),
    .level         (level),
    .level_change  (level_change),
    .missile_x     (missile_x),
    .missile_y     (missile_y),
    .missile_active(missile_active)
  );

  // ----------------------------------------
  // clock, frame tick, monitors
  // ----------------------------------------

  initial begin
    pclk = 1'b0;
    forever #4 pclk = ~pclk;
  end

  // one tick every 16 cycles once out of reset
  initial begin : frame_gen
    int phase;
    phase      = 0;
    frame_tick = 1'b0;
    forever begin
      @(posedge pclk);
      phase = rst ? 0 : (phase + 1) % FRAME_CYCLES;
      #1;
      frame_tick = (phase == FRAME_CYCLES - 1);
    end
  end

  // credit and level change pulses counted at the falling edge
  always @(negedge pclk) begin
    if (!rst && fire_credit) credits_back = credits_back + 1;
    if (!rst && level_change) lc_pulses = lc_pulses + 1;
  end

  // ----------------------------------------
  // helpers
  // ----------------------------------------

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
  endfunction

  function automatic int credits_held();
    return NUM_MISSILES - fires_sent + credits_back;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("timeout at %0t ns while waiting for %s", $time, what);
  endtask

  // returns 1 ns after the next tick edge
  task automatic next_tick();
    int n;
    n = 0;
    if (!timed_out) begin
      @(posedge pclk);
      while (!frame_tick && !timed_out) begin
        n++;
        if (n > TICK_LIMIT) report_timeout("a frame tick");
        else @(posedge pclk);
      end
      #1;
    end
  endtask

  task automatic run_frames(input int frames);
    for (int i = 0; i < frames; i++) begin
      next_tick();
    end
  endtask

  task automatic catch_credit_pulse();
    int n;
    n = 0;
    while (!timed_out && !fire_credit) begin
      if (n == CREDIT_LIMIT) begin
        report_timeout("a fire credit pulse");
      end else begin
        @(posedge pclk);
        #1;
        n++;
      end
    end
  endtask

  task automatic settle_credits();
    int n;
    n = 0;
    while (!timed_out && credits_held() != NUM_MISSILES) begin
      if (n == CREDIT_LIMIT) begin
        report_timeout("all fire credits to return");
      end else begin
        @(posedge pclk);
        #1;
        n++;
      end
    end
  endtask

  // one cycle fire request when a credit is in hand
  task automatic fire_missile(input coord_t x);
    if (credits_held() == 0) begin
      errors++;
      $display("fire requested at %0t ns with no credit held", $time);
    end else begin
      ship_x = x;
      fire   = 1'b1;
      fires_sent++;
      @(posedge pclk);
      #1;
      fire = 1'b0;
    end
  endtask

  // fire a few cycles after a tick and compare once the frames have run
  task automatic run_shot(input int s);
    coord_t x;
    int     frames;
    int     gap;
    x      = coord_t'(golden[s*SHOT_FIELDS]);
    frames = int'(golden[s*SHOT_FIELDS+1]);
    next_tick();
    rng_state = xorshift(rng_state);
    gap       = 1 + int'(rng_state[2:0]);
    repeat (gap) @(posedge pclk);
    #1;
    fire_missile(x);
    check_value("missile_active", 1, missile_active);
    check_value("missile_x[0]", x, missile_x[0]);
    check_value("missile_y[0]", MISSILE_START_Y, missile_y[0]);
    run_frames(frames);
    check_value("credits held", NUM_MISSILES, credits_held());
    settle_credits();
    check_value("alive_mask", golden[s*SHOT_FIELDS+2], alive_mask);
    check_value("kills", golden[s*SHOT_FIELDS+3], kills);
    check_value("level", golden[s*SHOT_FIELDS+4], level);
    check_value("level_change pulses", golden[s*SHOT_FIELDS+4], lc_pulses);
  endtask

  // ----------------------------------------
  // stimulus
  // ----------------------------------------

  initial begin
    rst    = 1'b1;
    fire   = 1'b0;
    ship_x = '0;
    $readmemh("verif/shooter_golden.txt", golden);
    repeat (5) @(posedge pclk);
    #1;
    rst = 1'b0;

    check_value("alive_mask", (1 << NUM_ENEMIES) - 1, alive_mask);
    check_value("kills", 0, kills);
    check_value("level", 0, level);
    check_value("missile_active", 0, missile_active);
    check_value("fire_credit", 0, fire_credit);
    check_value("level_change", 0, level_change);

    // two misses back to back at x 250 and 650 between the boxes
    next_tick();
    repeat (2) @(posedge pclk);
    #1;
    fire_missile(coord_t'(250));
    check_value("missile_active", 2'b01, missile_active);
    check_value("missile_x[0]", 250, missile_x[0]);
    check_value("missile_y[0]", MISSILE_START_Y, missile_y[0]);
    fire_missile(coord_t'(650));
    check_value("missile_active", 2'b11, missile_active);
    check_value("missile_x[1]", 650, missile_x[1]);
    // third shot held back
    check_value("credits held", 0, credits_held());

    next_tick();
    check_value("missile_y[0]", MISSILE_START_Y - MISSILE_STEP, missile_y[0]);
    check_value("missile_y[1]", MISSILE_START_Y - MISSILE_STEP, missile_y[1]);
    next_tick();
    check_value("missile_y[0]", MISSILE_START_Y - 2 * MISSILE_STEP, missile_y[0]);

    // both free on the same tick so credits leave one per cycle
    catch_credit_pulse();
    check_value("missile_active", 0, missile_active);
    @(posedge pclk);
    #1;
    check_value("fire_credit", 1, fire_credit);
    @(posedge pclk);
    #1;
    check_value("fire_credit", 0, fire_credit);
    check_value("credits held", NUM_MISSILES, credits_held());

    for (int s = 0; s < NUM_SHOTS; s++) begin
      if (!timed_out) run_shot(s);
    end

    $display("errors: %0d of %0d checks", errors, checks);
    if (errors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// File: src/shooter_core.sv
// ----------------------------------------
// shooter core
// playfield logic: launcher, formation,
// hit detectors and level control
// ----------------------------------------

`timescale 1ns/1ps

module shooter_core (
  input  logic                                                 pclk,
  input  logic                                                 rst,
  input  logic                                                 frame_tick,
  input  game_geom_pkg::coord_t                                ship_x,
  input  logic                                                 fire,
  output logic                                                 fire_credit,
  output game_ctrl_pkg::enemy_mask_t                           alive_mask,
  output game_ctrl_pkg::kill_cnt_t                             kills,
  output game_ctrl_pkg::level_t                                level,
  output logic                                                 level_change,
  output game_geom_pkg::coord_t [game_ctrl_pkg::NUM_MISSILES-1:0] missile_x,
  output game_geom_pkg::coord_t [game_ctrl_pkg::NUM_MISSILES-1:0] missile_y,
  output logic [game_ctrl_pkg::NUM_MISSILES-1:0]               missile_active
);

  import game_geom_pkg::*;
  import game_ctrl_pkg::*;

  coord_t [NUM_ENEMIES-1:0] enemy_x;
  logic   [NUM_MISSILES-1:0] enemy_hit [NUM_ENEMIES];
  logic   [NUM_MISSILES-1:0] missile_hit;

  // any enemy struck by a missile frees its slot
  always_comb begin
    missile_hit = '0;
    for (int i = 0; i < NUM_ENEMIES; i++) begin
      missile_hit = missile_hit | enemy_hit[i];
    end
  end

  missile_launcher u_launcher (
    .pclk          (pclk),
    .rst           (rst),
    .frame_tick    (frame_tick),
    .fire          (fire),
    .ship_x        (ship_x),
    .missile_hit   (missile_hit),
    .missile_x     (missile_x),
    .missile_y     (missile_y),
    .missile_active(missile_active),
    .fire_credit   (fire_credit)
  );

  enemy_formation u_formation (
    .pclk        (pclk),
    .rst         (rst),
    .frame_tick  (frame_tick),
    .level_change(level_change),
    .enemy_x     (enemy_x)
  );

  for (genvar i = 0; i < NUM_ENEMIES; i++) begin : g_detect
    enemy_hit_detect u_detect (
      .pclk          (pclk),
      .rst           (rst),
      .level_change  (level_change),
      .enemy_x       (enemy_x[i]),
      .missile_x     (missile_x),
      .missile_y     (missile_y),
      .missile_active(missile_active),
      .alive         (alive_mask[i]),
      .hit           (enemy_hit[i])
    );
  end

  level_control u_level (
    .pclk        (pclk),
    .rst         (rst),
    .alive_mask  (alive_mask),
    .kills       (kills),
    .level       (level),
    .level_change(level_change)
  );

endmodule

// File: src/level_control.sv
// ----------------------------------------
// level control
// counts kills, flags level change when
// the whole row is dead
// ----------------------------------------

`timescale 1ns/1ps

module level_control (
  input  logic                       pclk,
  input  logic                       rst,
  input  game_ctrl_pkg::enemy_mask_t alive_mask,
  output game_ctrl_pkg::kill_cnt_t   kills,
  output game_ctrl_pkg::level_t      level,
  output logic                       level_change
);

  import game_ctrl_pkg::*;

  enemy_mask_t prev_mask;
  kill_cnt_t   new_kills;
  logic        row_cleared;

  // falling alive bits since last cycle, two may drop together
  always_comb begin
    new_kills = '0;
    for (int i = 0; i < NUM_ENEMIES; i++) begin
      if (prev_mask[i] && !alive_mask[i]) begin
        new_kills = new_kills + 1'b1;
      end
    end
  end

  // mask stays zero for two cycles, pulse only on the first
  assign row_cleared = (alive_mask == '0) && !level_change;

  always_ff @(posedge pclk) begin
    if (rst) begin
      prev_mask    <= '1;
      kills        <= '0;
      level        <= '0;
      level_change <= 1'b0;
    end else begin
      prev_mask    <= alive_mask;
      level_change <= row_cleared;
      if (row_cleared) begin
        level <= level + 1'b1;
      end
      // clears with the row coming back
      if (level_change) begin
        kills <= '0;
      end else begin
        kills <= kills + new_kills;
      end
    end
  end

endmodule

// File: src/enemy_hit_detect.sv
// ----------------------------------------
// enemy hit detector
// switches one enemy off when a missile
// enters its box, back on at level change
// ----------------------------------------

`timescale 1ns/1ps

module enemy_hit_detect (
  input  logic                                                 pclk,
  input  logic                                                 rst,
  input  logic                                                 level_change,
  input  game_geom_pkg::coord_t                                enemy_x,
  input  game_geom_pkg::coord_t [game_ctrl_pkg::NUM_MISSILES-1:0] missile_x,
  input  game_geom_pkg::coord_t [game_ctrl_pkg::NUM_MISSILES-1:0] missile_y,
  input  logic [game_ctrl_pkg::NUM_MISSILES-1:0]               missile_active,
  output logic                                                 alive,
  output logic [game_ctrl_pkg::NUM_MISSILES-1:0]               hit
);

  import game_geom_pkg::*;
  import game_ctrl_pkg::*;

  alive_state_e state;
  alive_state_e state_nxt;

  logic [NUM_MISSILES-1:0] in_box;

  // box test per missile, all bounds inclusive
  always_comb begin
    for (int i = 0; i < NUM_MISSILES; i++) begin
      in_box[i] = missile_active[i] &&
                  (missile_x[i] >= enemy_x - HALF_WIDTH_ENEMY) &&
                  (missile_x[i] <= enemy_x + HALF_WIDTH_ENEMY) &&
                  (missile_y[i] >= ENEMY_ROW_Y) &&
                  (missile_y[i] <= ENEMY_ROW_Y + HEIGHT_ENEMY);
    end
  end

  // ----------------------------------------
  // alive FSM
  // ----------------------------------------

  always_comb begin
    state_nxt = state;
    case (state)
      ALIVE:   if (|in_box) state_nxt = DEAD;
      DEAD:    if (level_change) state_nxt = ALIVE;
      default: state_nxt = ALIVE;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      state <= ALIVE;
      hit   <= '0;
    end else begin
      state <= state_nxt;
      // a dead enemy absorbs nothing
      hit   <= (state == ALIVE) ? in_box : '0;
    end
  end

  assign alive = (state == ALIVE);

endmodule

// File: src/enemy_formation.sv
// ----------------------------------------
// enemy formation
// sweeping row offset and enemy centre x
// ----------------------------------------

`timescale 1ns/1ps

module enemy_formation (
  input  logic                                                pclk,
  input  logic                                                rst,
  input  logic                                                frame_tick,
  input  logic                                                level_change,
  output game_geom_pkg::coord_t [game_ctrl_pkg::NUM_ENEMIES-1:0] enemy_x
);

  import game_geom_pkg::*;
  import game_ctrl_pkg::*;

  sweep_dir_e dir;
  sweep_dir_e dir_nxt;
  coord_t     offset;
  coord_t     offset_nxt;

  // ----------------------------------------
  // direction FSM and offset
  // ----------------------------------------

  // sequence runs 0,1..SWEEP_MAX,SWEEP_MAX-1..0,1
  always_comb begin
    dir_nxt    = dir;
    offset_nxt = offset;
    if (level_change) begin
      dir_nxt    = SWEEP_RIGHT;
      offset_nxt = '0;
    end else if (frame_tick) begin
      case (dir)
        SWEEP_RIGHT: begin
          if (offset >= SWEEP_MAX) begin
            dir_nxt    = SWEEP_LEFT;
            offset_nxt = offset - 1'b1;
          end else begin
            offset_nxt = offset + 1'b1;
          end
        end
        SWEEP_LEFT: begin
          if (offset == '0) begin
            dir_nxt    = SWEEP_RIGHT;
            offset_nxt = offset + 1'b1;
          end else begin
            offset_nxt = offset - 1'b1;
          end
        end
        default: begin
          dir_nxt    = SWEEP_RIGHT;
          offset_nxt = '0;
        end
      endcase
    end
  end

  always_ff @(posedge pclk) begin
    if (rst) begin
      dir    <= SWEEP_RIGHT;
      offset <= '0;
    end else begin
      dir    <= dir_nxt;
      offset <= offset_nxt;
    end
  end

  // ----------------------------------------
  // per enemy centre x
  // ----------------------------------------

  for (genvar i = 0; i < NUM_ENEMIES; i++) begin : g_enemy_x
    localparam coord_t SLOT_X = coord_t'(ENEMY_BASE_X + ENEMY_SPACING * i);
    assign enemy_x[i] = SLOT_X + offset;
  end

endmodule

// File: src/missile_launcher.sv
// ----------------------------------------
// missile launcher
// two missile slots, climb per frame,
// slot release with fire credit return
// ----------------------------------------

`timescale 1ns/1ps

module missile_launcher (
  input  logic                                                 pclk,
  input  logic                                                 rst,
  input  logic                                                 frame_tick,
  input  logic                                                 fire,
  input  game_geom_pkg::coord_t                                ship_x,
  input  logic [game_ctrl_pkg::NUM_MISSILES-1:0]               missile_hit,
  output game_geom_pkg::coord_t [game_ctrl_pkg::NUM_MISSILES-1:0] missile_x,
  output game_geom_pkg::coord_t [game_ctrl_pkg::NUM_MISSILES-1:0] missile_y,
  output logic [game_ctrl_pkg::NUM_MISSILES-1:0]               missile_active,
  output logic                                                 fire_credit
);

  import game_geom_pkg::*;
  import game_ctrl_pkg::*;

  // wide enough for every slot freeing plus one held credit
  localparam int CW = $clog2(NUM_MISSILES + 2);

  logic [NUM_MISSILES-1:0] load;
  logic [NUM_MISSILES-1:0] free;
  logic [CW-1:0]           credit_sum;
  logic                    pending;
  coord_t                  launch_x;

  // ship past the right edge pins to the last column
  assign launch_x = (ship_x < SCREEN_W) ? ship_x : SCREEN_W - coord_t'(1);

  // ----------------------------------------
  // slot selection and release
  // ----------------------------------------

  // fire goes to the lowest idle slot, dropped if none
  always_comb begin
    logic taken;
    taken = 1'b0;
    load  = '0;
    for (int i = 0; i < NUM_MISSILES; i++) begin
      if (fire && !missile_active[i] && !taken) begin
        load[i] = 1'b1;
        taken   = 1'b1;
      end
    end
  end

  // hit wins over motion, top of screen frees on the tick
  always_comb begin
    for (int i = 0; i < NUM_MISSILES; i++) begin
      free[i] = missile_active[i] &&
                (missile_hit[i] || (frame_tick && missile_y[i] < MISSILE_STEP));
    end
  end

  // credits owed this cycle, one goes out, the rest waits
  always_comb begin
    credit_sum = CW'(pending);
    for (int i = 0; i < NUM_MISSILES; i++) begin
      credit_sum = credit_sum + CW'(free[i]);
    end
  end

  // ----------------------------------------
  // control registers
  // ----------------------------------------

  always_ff @(posedge pclk) begin
    if (rst) begin
      missile_active <= '0;
      fire_credit    <= 1'b0;
      pending        <= 1'b0;
    end else begin
      for (int i = 0; i < NUM_MISSILES; i++) begin
        if (free[i]) begin
          missile_active[i] <= 1'b0;
        end else if (load[i]) begin
          missile_active[i] <= 1'b1;
        end
      end
      fire_credit <= (credit_sum != '0);
      pending     <= (credit_sum > CW'(1));
    end
  end

  // positions
  always_ff @(posedge pclk) begin
    for (int i = 0; i < NUM_MISSILES; i++) begin
      if (load[i]) begin
        missile_x[i] <= launch_x;
        missile_y[i] <= MISSILE_START_Y;
      end else if (missile_active[i] && frame_tick) begin
        missile_y[i] <= missile_y[i] - MISSILE_STEP;
      end
    end
  end

endmodule

// File: src/game_ctrl_pkg.sv
// ----------------------------------------
// game control
// object counts, mask, kill and level
// types, FSM state encodings
// ----------------------------------------

package game_ctrl_pkg;

  // ----------------------------------------
  // counts
  // ----------------------------------------

  localparam int NUM_ENEMIES  = 4;
  // also the number of fire credits after reset
  localparam int NUM_MISSILES = 2;

  // ----------------------------------------
  // types
  // ----------------------------------------

  // one bit per enemy, set while alive
  typedef logic [NUM_ENEMIES-1:0] enemy_mask_t;

  // kills in the current level
  typedef logic [2:0] kill_cnt_t;

  // level number, wraps
  typedef logic [3:0] level_t;

  // hit detector state
  typedef enum logic {ALIVE, DEAD} alive_state_e;

  // formation direction
  typedef enum logic {SWEEP_RIGHT, SWEEP_LEFT} sweep_dir_e;

endpackage

// File: src/game_geom_pkg.sv
// ----------------------------------------
// game geometry
// screen size, sprite boxes, motion steps
// and the screen coordinate type
// ----------------------------------------

package game_geom_pkg;

  // one screen coordinate, x or y
  typedef logic [10:0] coord_t;

  // ----------------------------------------
  // playfield
  // ----------------------------------------

  localparam coord_t SCREEN_W = coord_t'(800);
  localparam coord_t SCREEN_H = coord_t'(600);

  // ----------------------------------------
  // enemy sprite and hit box
  // ----------------------------------------

  // box spans x-25..x+25 and y..y+50, ends inclusive
  localparam coord_t HALF_WIDTH_ENEMY = coord_t'(25);
  localparam coord_t HEIGHT_ENEMY     = coord_t'(50);

  // top edge shared by the whole row
  localparam coord_t ENEMY_ROW_Y = coord_t'(100);

  // centre x of enemy i is base + spacing * i + sweep offset
  localparam coord_t ENEMY_BASE_X  = coord_t'(100);
  localparam coord_t ENEMY_SPACING = coord_t'(200);

  // offset bounces 0..SWEEP_MAX, one pixel per frame
  localparam coord_t SWEEP_MAX = coord_t'(100);

  // ----------------------------------------
  // missiles
  // ----------------------------------------

  // launch height, a little above the bottom edge where the ship sits
  localparam coord_t MISSILE_START_Y = SCREEN_H - coord_t'(40);

  // climb per frame
  localparam coord_t MISSILE_STEP = coord_t'(8);

endpackage
